/* list.f */
logic/zx_ports_pkg.sv
logic/mem_paging_regs.sv
logic/sd_card_ports.sv
logic/port_read_merge.sv
logic/zx_ports.sv
tb/zx_ports_tb.sv

/* logic/mem_paging_regs.sv */
// FE, 7FFD and xxAF port decode; holds the paging and system configuration registers
`timescale 1ns/1ps

module mem_paging_regs (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [15:0]                   a,
	input  zx_ports_pkg::byte_t           din,
	input  logic                          iowr_s,	// one cycle io write
	input  logic                          opfetch,	// opcode on din
	input  logic [zx_ports_pkg::KEYS_W-1:0] keys_in,
	input  logic                          tape_read,
	output logic                          pg_hit,
	output zx_ports_pkg::byte_t           pg_rdata,
	output logic                          border_wr,
	output logic                          beeper_wr,
	output logic [31:0]                   xt_page,
	output zx_ports_pkg::byte_t           sysconf,
	output zx_ports_pkg::byte_t           memconf,
	output logic [3:0]                    cacheconf,
	output logic [4:0]                    fmaddr,
	output zx_ports_pkg::byte_t           intmask
);

	import zx_ports_pkg::*;

	byte_t loa;
	byte_t hoa;
	byte_t rampage [0:3];

	logic portfe_wr;
	logic portxt_wr;
	logic p7ffd_wr;
	logic p7ffd_blocked;

	logic lock48;
	logic lock128;
	logic lock128_2;
	logic lock128_3;
	logic m1_lock128;
	logic [2:0] p7_mid;	// rampage 3 bits 5:3

	assign loa = a[7:0];
	assign hoa = a[15:8];

	assign portfe_wr = (loa == PORT_FE) && iowr_s;
	assign portxt_wr = (loa == PORT_XT) && iowr_s;
	assign p7ffd_wr = !a[15] && (loa == PORT_FD) && iowr_s && !lock48;
	assign p7ffd_blocked = !a[15] && (loa == PORT_FD) && iowr_s && lock48;

	assign beeper_wr = portfe_wr;
	// border from FE or from the extended border register
	assign border_wr = portfe_wr || (portxt_wr && (hoa == XT_XBORDER));

	assign xt_page = {rampage[3], rampage[2], rampage[1], rampage[0]};

	// memconf lock modes
	assign lock128_2 = (memconf[7:6] == 2'b10);
	assign lock128_3 = (memconf[7:6] == 2'b11);	// 512K, lock off
	assign lock128 = lock128_3 ? 1'b0 : (lock128_2 ? m1_lock128 : memconf[6]);

	assign p7_mid = lock128_3 ? {din[5], din[7:6]} : {1'b0, lock128 ? 2'b00 : din[7:6]};

	// mode 2 decides from the last opcode
	always_ff @(posedge clk)
	begin
		if (rst)
			m1_lock128 <= 1'b0;
		else if (opfetch)
			m1_lock128 <= !(din[7] ^ din[6]);
	end

	// 48K lock, only cleared by reset
	always_ff @(posedge clk)
	begin
		if (rst)
			lock48 <= 1'b0;
		else if (p7ffd_wr && !lock128_3)
			lock48 <= din[5];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sysconf <= SYSCONF_RST;
			memconf <= MEMCONF_RST;
			intmask <= INTMASK_RST;
			cacheconf <= 4'h0;	// cache off
			fmaddr <= 5'd0;
			rampage[0] <= RAMPAGE0_RST;
			rampage[1] <= RAMPAGE1_RST;
			rampage[2] <= RAMPAGE2_RST;
			rampage[3] <= RAMPAGE3_RST;
		end
		else if (p7ffd_wr)
		begin
			memconf[0] <= din[4];	// rom select
			rampage[3] <= {2'b00, p7_mid, din[2:0]};
		end
		else if (portxt_wr)
		begin
			if (hoa[7:2] == XT_RAMPAGE[7:2])
				rampage[hoa[1:0]] <= din;

			case (hoa)
				XT_FMADDR:
					fmaddr <= din[4:0];
				XT_SYSCONF:
				begin
					sysconf <= din;
					cacheconf <= {4{din[2]}};	// cache follows the turbo bit
				end
				XT_MEMCONF:
					memconf <= din;
				XT_INTMASK:
					intmask <= din;
				XT_CACHECONF:
					cacheconf <= din[3:0];
				default:
					;
			endcase
		end
	end

	// read side
	assign pg_hit = (loa == PORT_FE) || (loa == PORT_FD) || (loa == PORT_XT);

	always_comb
	begin
		pg_rdata = 8'hFF;
		if (loa == PORT_FE)
			pg_rdata = {1'b1, tape_read, 1'b0, keys_in};
		else if ((loa == PORT_XT) && (hoa[7:2] == XT_RAMPAGE[7:2]) && hoa[1])
			pg_rdata = rampage[hoa[1:0]];	// only 12 and 13 readable
	end

	// once locked, 7FFD no longer moves the pages
	lock48_holds: assert property (@(posedge clk) disable iff (rst)
		p7ffd_blocked |=> $stable(xt_page));

	reset_values: assert property (@(posedge clk)
		rst |=> (xt_page == {RAMPAGE3_RST, RAMPAGE2_RST, RAMPAGE1_RST, RAMPAGE0_RST})
			&& (sysconf == SYSCONF_RST) && (memconf == MEMCONF_RST)
			&& (intmask == INTMASK_RST) && (cacheconf == 4'h0));

endmodule

/* logic/port_read_merge.sv */
// merges the hits and read bytes of the paging and SD port groups onto the Z80 read bus
`timescale 1ns/1ps

module port_read_merge (
	input  logic                pg_hit,
	input  logic                sd_hit,
	input  logic                iord,	// io read cycle level
	input  zx_ports_pkg::byte_t pg_rdata,
	input  zx_ports_pkg::byte_t sd_rdata,
	output logic                porthit,
	output logic                dataout,
	output zx_ports_pkg::byte_t dout
);

	import zx_ports_pkg::*;

	byte_t sel_data;

	// internal port, keeps the external bus quiet
	assign porthit = pg_hit || sd_hit;

	always_comb
	begin
		if (pg_hit)
			sel_data = pg_rdata;
		else if (sd_hit)
			sel_data = sd_rdata;
		else
			sel_data = 8'hFF;	// open bus
	end

	assign dout = sel_data;

	// drive the cpu data bus only on our own read
	assign dataout = porthit && iord;

	// address decodes of the two groups must not overlap
	always_comb
	begin
		hits_exclusive: assert final (!(pg_hit && sd_hit))
			else $error("paging and sd ports hit together");
	end

endmodule

/* logic/sd_card_ports.sv */
// SD card SPI port pair 77/57; drives chip select and the transfer start for the SPI master
`timescale 1ns/1ps

module sd_card_ports (
	input  logic                clk,
	input  logic                rst,
	input  logic [7:0]          a,	// low address byte
	input  zx_ports_pkg::byte_t din,
	input  logic                iowr_s,
	input  logic                iord_s,
	input  logic                wr,
	input  logic                dos,
	input  logic                vdos,
	input  zx_ports_pkg::byte_t sd_dataout,	// last byte shifted in
	output logic                sd_hit,
	output zx_ports_pkg::byte_t sd_rdata,
	output logic                sdcs_n,
	output logic                sd_start,
	output zx_ports_pkg::byte_t sd_datain
);

	import zx_ports_pkg::*;

	logic sd_en;
	logic sdcfg_wr;
	logic sddat_wr;
	logic sddat_rd;

	// hidden while the dos rom is paged, unless virtual dos
	assign sd_en = !dos || vdos;

	assign sdcfg_wr = (a == SD_CFG) && iowr_s && sd_en;
	assign sddat_wr = (a == SD_DAT) && iowr_s && sd_en;
	assign sddat_rd = (a == SD_DAT) && iord_s;

	always_ff @(posedge clk)
	begin
		if (rst)
			sdcs_n <= 1'b1;	// card deselected
		else if (sdcfg_wr)
			sdcs_n <= din[1];
	end

	assign sd_start = sddat_wr || sddat_rd;	// each access runs one byte
	assign sd_datain = wr ? din : 8'hFF;	// reads shift out all ones

	assign sd_hit = ((a == SD_CFG) || (a == SD_DAT)) && sd_en;

	// 77 reads as card present and writable
	assign sd_rdata = (a == SD_DAT) ? sd_dataout : ((a == SD_CFG) ? 8'h00 : 8'hFF);

	start_from_strobe: assert property (@(posedge clk) disable iff (rst)
		sd_start |-> (iowr_s || iord_s));

endmodule

/* logic/zx_ports.sv */
// Z80 I/O port block top level; connects the paging registers, the SD ports and the read merge
`timescale 1ns/1ps

module zx_ports (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [15:0]                   a,
	input  zx_ports_pkg::byte_t           din,
	input  logic                          iowr_s,
	input  logic                          iord_s,
	input  logic                          iord,
	input  logic                          wr,
	input  logic                          opfetch,
	input  logic                          dos,
	input  logic                          vdos,
	input  logic [zx_ports_pkg::KEYS_W-1:0] keys_in,
	input  logic                          tape_read,
	input  zx_ports_pkg::byte_t           sd_dataout,
	output zx_ports_pkg::byte_t           dout,
	output logic                          dataout,
	output logic                          porthit,
	output logic                          border_wr,
	output logic                          beeper_wr,
	output logic [31:0]                   xt_page,	// rampage 3..0
	output zx_ports_pkg::byte_t           sysconf,
	output zx_ports_pkg::byte_t           memconf,
	output logic [3:0]                    cacheconf,
	output logic [4:0]                    fmaddr,
	output zx_ports_pkg::byte_t           intmask,
	output logic                          sdcs_n,
	output logic                          sd_start,
	output zx_ports_pkg::byte_t           sd_datain
);

	import zx_ports_pkg::*;

	logic  pg_hit;
	logic  sd_hit;
	byte_t pg_rdata;
	byte_t sd_rdata;

	mem_paging_regs u_paging (
		.clk       (clk),
		.rst       (rst),
		.a         (a),
		.din       (din),
		.iowr_s    (iowr_s),
		.opfetch   (opfetch),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.pg_hit    (pg_hit),
		.pg_rdata  (pg_rdata),
		.border_wr (border_wr),
		.beeper_wr (beeper_wr),
		.xt_page   (xt_page),
		.sysconf   (sysconf),
		.memconf   (memconf),
		.cacheconf (cacheconf),
		.fmaddr    (fmaddr),
		.intmask   (intmask)
	);

	// sd ports decode the low byte only
	sd_card_ports u_sd (
		.clk        (clk),
		.rst        (rst),
		.a          (a[7:0]),
		.din        (din),
		.iowr_s     (iowr_s),
		.iord_s     (iord_s),
		.wr         (wr),
		.dos        (dos),
		.vdos       (vdos),
		.sd_dataout (sd_dataout),
		.sd_hit     (sd_hit),
		.sd_rdata   (sd_rdata),
		.sdcs_n     (sdcs_n),
		.sd_start   (sd_start),
		.sd_datain  (sd_datain)
	);

	port_read_merge u_merge (
		.pg_hit   (pg_hit),
		.sd_hit   (sd_hit),
		.iord     (iord),
		.pg_rdata (pg_rdata),
		.sd_rdata (sd_rdata),
		.porthit  (porthit),
		.dataout  (dataout),
		.dout     (dout)
	);

endmodule

/* logic/zx_ports_pkg.sv */
// shared port addresses, xxAF register numbers and reset values for the I/O port block and its testbench
package zx_ports_pkg;

	typedef logic [7:0] byte_t;	// one Z80 data byte

	// low address bytes
	localparam byte_t PORT_FE = 8'hFE;	// border, beeper, keyboard
	localparam byte_t PORT_FD = 8'hFD;	// 7FFD paging with a15 low
	localparam byte_t PORT_XT = 8'hAF;	// extended registers, high byte selects
	localparam byte_t SD_CFG  = 8'h77;	// sd chip select
	localparam byte_t SD_DAT  = 8'h57;	// sd spi data

	// xxAF register numbers, taken from the high address byte
	localparam byte_t XT_XBORDER   = 8'h0F;
	localparam byte_t XT_RAMPAGE   = 8'h10;	// 10 to 13, one per 16K window
	localparam byte_t XT_FMADDR    = 8'h15;
	localparam byte_t XT_SYSCONF   = 8'h20;
	localparam byte_t XT_MEMCONF   = 8'h21;
	localparam byte_t XT_INTMASK   = 8'h2A;
	localparam byte_t XT_CACHECONF = 8'h2B;

	// register values after reset
	localparam byte_t SYSCONF_RST  = 8'h01;	// 7 MHz turbo
	localparam byte_t MEMCONF_RST  = 8'h04;	// rom mapping off
	localparam byte_t INTMASK_RST  = 8'h01;	// frame interrupt only

	// default 128K layout: rom, page 5, page 2, page 0
	localparam byte_t RAMPAGE0_RST = 8'h00;
	localparam byte_t RAMPAGE1_RST = 8'h05;
	localparam byte_t RAMPAGE2_RST = 8'h02;
	localparam byte_t RAMPAGE3_RST = 8'h00;

	// keyboard column lines on port FE
	localparam int KEYS_W = 5;

endpackage

/* tb/zx_ports_tb.sv */
// testbench for the I/O port block; replays the step list in tb/zx_ports_tests.mem against the DUT
`timescale 1ns/1ps

module zx_ports_tb;

	import zx_ports_pkg::*;

	localparam int MAX_STEPS     = 128;
	localparam int RESET_TIMEOUT = 20;	// cycles

	logic clk;
	logic rst;
	logic [15:0] a;
	byte_t din;
	logic iowr_s, iord_s, iord, wr, opfetch;
	logic dos, vdos;
	logic [KEYS_W-1:0] keys_in;
	logic tape_read;
	byte_t sd_dataout;

	byte_t dout, sysconf, memconf, intmask, sd_datain;
	logic dataout, porthit, border_wr, beeper_wr, sdcs_n, sd_start;
	logic [31:0] xt_page;
	logic [3:0] cacheconf;
	logic [4:0] fmaddr;

	// op, address, data, dos, vdos, expected, flags
	logic [71:0] steps [0:MAX_STEPS-1];
	logic [31:0] lfsr_state;
	int cur_step;
	logic done;

	zx_ports UUT (.*);

	initial
		clk = 1'b0;

	always #20 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1, shifting right
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic string label(input string name);
		label = $sformatf("step %0d %s", cur_step, name);
	endfunction

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "%s", why);
	endtask

	task automatic wait_reset_release();
		logic ready;
		ready = 1'b0;
		for (int i = 0; i < RESET_TIMEOUT && !ready; i++)
		begin
			@(posedge clk);
			#1;
			ready = (sdcs_n === 1'b1) && (border_wr === 1'b0);
		end
		if (!ready)
			abort_run("timed out waiting for the port block to leave reset");
	endtask

	// AF reads of 12 and 13 give back the rampage 2 and 3 bytes of xt_page
	task automatic read_back_pages(input logic [31:0] pages);
		for (int k = 2; k < 4; k++)
		begin
			@(negedge clk);
			a = {XT_RAMPAGE[7:2], k[1:0], PORT_XT};
			iowr_s = 1'b0;
			wr = 1'b0;
			opfetch = 1'b0;
			iord_s = 1'b1;
			iord = 1'b1;
			@(posedge clk);
			#1;
			compare(dout, pages[8*k +: 8], label($sformatf("rampage %0d read", k)));
			compare(porthit, 1'b1, label("porthit"));
		end
	endtask

	task automatic run_step(input logic [71:0] s);
		logic [3:0] op;
		logic [3:0] flags;
		logic [31:0] exp;
		logic [31:0] bits;
		byte_t rd_exp;
		op = s[71:68];
		exp = s[35:4];
		flags = s[3:0];
		if (!(op inside {4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6}))
			abort_run($sformatf("unknown opcode %h in test step %0d", op, cur_step));
		@(negedge clk);
		take_bits(KEYS_W, bits);
		keys_in = bits[KEYS_W-1:0];
		take_bits(1, bits);
		tape_read = bits[0];
		take_bits(8, bits);
		sd_dataout = bits[7:0];
		a = s[67:52];
		din = s[51:44];
		dos = s[40];
		vdos = s[36];
		iowr_s = (op == 4'h1);
		wr = (op == 4'h1);
		iord_s = (op == 4'h2) || (op == 4'h5) || (op == 4'h6);
		iord = iord_s;
		opfetch = (op == 4'h3);
		@(posedge clk);
		#1;
		case (op)
			4'h1:
			begin
				compare(border_wr, flags[0], label("border_wr"));
				compare(beeper_wr, flags[1], label("beeper_wr"));
				compare(sd_start, flags[2], label("sd_start"));
				compare(porthit, flags[3], label("porthit"));
				compare(dataout, 1'b0, label("dataout"));
				compare(sd_datain, din, label("sd_datain"));
			end
			4'h2, 4'h5, 4'h6:
			begin
				if (op == 4'h5)
					rd_exp = {1'b1, tape_read, 1'b0, keys_in};	// FE layout
				else if (op == 4'h6)
					rd_exp = (!dos || vdos) ? sd_dataout : 8'hFF;
				else
					rd_exp = exp[7:0];
				compare(dout, rd_exp, label("dout"));
				compare(porthit, flags[3], label("porthit"));
				compare(dataout, flags[3], label("dataout"));
				compare(sd_start, flags[2], label("sd_start"));
				compare(sd_datain, 8'hFF, label("sd_datain"));
			end
			4'h4:
			begin
				compare(border_wr, 1'b0, label("border_wr"));
				compare(beeper_wr, 1'b0, label("beeper_wr"));
				case (din)
					8'h00:
					begin
						compare(xt_page, exp, label("xt_page"));
						read_back_pages(exp);
					end
					8'h01: compare(sysconf, exp, label("sysconf"));
					8'h02: compare(memconf, exp, label("memconf"));
					8'h03: compare(intmask, exp, label("intmask"));
					8'h04: compare(cacheconf, exp, label("cacheconf"));
					8'h05: compare(fmaddr, exp, label("fmaddr"));
					8'h06: compare(sdcs_n, exp, label("sdcs_n"));
					default: abort_run($sformatf("bad register select in step %0d", cur_step));
				endcase
			end
			default:
				compare(sd_start, 1'b0, label("sd_start"));	// opcode fetch only
		endcase
	endtask

	initial
	begin
		a = '0;
		din = '0;
		iowr_s = 1'b0;
		iord_s = 1'b0;
		iord = 1'b0;
		wr = 1'b0;
		opfetch = 1'b0;
		dos = 1'b0;
		vdos = 1'b0;
		keys_in = '0;
		tape_read = 1'b0;
		sd_dataout = '0;
		lfsr_state = 32'h5578b391;
		cur_step = 0;
		done = 1'b0;
		rst = 1'b1;
		$readmemh("tb/zx_ports_tests.mem", steps);
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		wait_reset_release();

		for (int i = 0; i < MAX_STEPS && !done; i++)
		begin
			cur_step = i;
			if (steps[i][71:68] === 4'hF)
				done = 1'b1;	// end marker
			else
				run_step(steps[i]);
		end

		if (done)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
			abort_run("test file has no end marker");
	end

endmodule

/* tb/zx_ports_tests.mem */
// op_addr_data_dos_vdos_expect_flags; op 1 write 2 read 3 opfetch 4 check 5 FE read 6 57 read F end
// flags porthit sd_start beeper_wr border_wr; check data 0 xt_page 1 sysconf 2 memconf 3 intmask 4 cacheconf 5 fmaddr 6 sdcs_n
4_0000_00_0_0_00020500_0
4_0000_01_0_0_00000001_0
4_0000_02_0_0_00000004_0
4_0000_03_0_0_00000001_0
4_0000_04_0_0_00000000_0
4_0000_06_0_0_00000001_0
1_10AF_3C_0_0_00000000_8
1_11AF_1A_0_0_00000000_8
1_12AF_47_0_0_00000000_8
1_13AF_C5_0_0_00000000_8
4_0000_00_0_0_C5471A3C_0
2_11AF_00_0_0_000000FF_8
2_20AF_00_0_0_000000FF_8
1_15AF_E9_0_0_00000000_8
4_0000_05_0_0_00000009_0
1_20AF_06_0_0_00000000_8
4_0000_01_0_0_00000006_0
4_0000_04_0_0_0000000F_0
1_2BAF_A5_0_0_00000000_8
4_0000_04_0_0_00000005_0
1_2AAF_3F_0_0_00000000_8
4_0000_03_0_0_0000003F_0
1_0FAF_07_0_0_00000000_9
1_7FFD_13_0_0_00000000_8
4_0000_00_0_0_03471A3C_0
4_0000_02_0_0_00000005_0
1_7FFD_C6_0_0_00000000_8
4_0000_00_0_0_1E471A3C_0
1_21AF_44_0_0_00000000_8
1_7FFD_D5_0_0_00000000_8
4_0000_00_0_0_05471A3C_0
1_21AF_84_0_0_00000000_8
3_0000_C0_0_0_00000000_0
1_7FFD_C2_0_0_00000000_8
4_0000_00_0_0_02471A3C_0
3_0000_40_0_0_00000000_0
1_7FFD_81_0_0_00000000_8
4_0000_00_0_0_11471A3C_0
1_21AF_C4_0_0_00000000_8
1_7FFD_37_0_0_00000000_8
4_0000_00_0_0_27471A3C_0
4_0000_02_0_0_000000C5_0
1_7FFD_E0_0_0_00000000_8
4_0000_00_0_0_38471A3C_0
1_FFFD_07_0_0_00000000_8
4_0000_00_0_0_38471A3C_0
1_21AF_04_0_0_00000000_8
1_7FFD_23_0_0_00000000_8
1_7FFD_17_0_0_00000000_8
4_0000_00_0_0_03471A3C_0
4_0000_02_0_0_00000004_0
5_FEFE_00_0_0_00000000_8
5_7FFE_00_0_0_00000000_8
1_00FE_15_0_0_00000000_B
1_0077_FD_0_0_00000000_8
4_0000_06_0_0_00000000_0
1_0077_02_0_0_00000000_8
1_0057_A5_0_0_00000000_C
2_0077_00_0_0_00000000_8
6_0057_00_0_0_00000000_C
1_0077_00_1_0_00000000_0
1_0057_33_1_0_00000000_0
2_0057_00_1_0_000000FF_4
4_0000_06_0_0_00000001_0
1_0077_00_1_1_00000000_8
4_0000_06_0_0_00000000_0
2_1234_00_0_0_000000FF_0
F_0000_00_0_0_00000000_0
